// ==== design/char_class.sv ====
// character classifier: hex digit, alphanumeric and nybble value
`default_nettype none

module char_class (
	input  term_msg_pkg::char_t ch,
	output logic                is_hex,
	output logic                is_alnum,
	output logic [3:0]          nybble
);

	logic is_digit;
	logic is_lower;
	logic is_upper;
	logic is_hex_letter;

	assign is_digit = (ch >= "0") && (ch <= "9");
	assign is_lower = (ch >= "a") && (ch <= "z");
	assign is_upper = (ch >= "A") && (ch <= "Z");
	assign is_hex_letter = ((ch >= "a") && (ch <= "f")) || ((ch >= "A") && (ch <= "F"));

	assign is_hex = is_digit || is_hex_letter;
	assign is_alnum = is_digit || is_lower || is_upper;

	// both letter cases have 1..6 in the low nybble
	assign nybble = is_digit ? ch[3:0] :
		is_hex_letter ? (ch[3:0] + 4'd9) : 4'd0;

endmodule

`default_nettype wire

// ==== design/hex_to_ascii.sv ====
// bus data word to eight uppercase ASCII hex characters
`default_nettype none

module hex_to_ascii (
	input  term_bus_pkg::data_t value,
	output logic [63:0]         text
);

	always_comb begin
		logic [3:0] nyb;
		text = '0;
		// most significant nybble becomes the first character
		for (int i = 0; i < 8; i++) begin
			nyb = value[31 - 4 * i -: 4];
			if (nyb < 4'd10) begin
				text[63 - 8 * i -: 8] = 8'h30 + {4'd0, nyb};
			end else begin
				text[63 - 8 * i -: 8] = 8'h37 + {4'd0, nyb};
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/msg_rx.sv ====
// inbound message assembly and flag decode
`default_nettype none

module msg_rx (
	input  logic                     clk,
	input  logic                     arst,
	input  term_msg_pkg::char_t      rx_byte,
	input  logic                     rx_valid,
	output logic                     msg_valid,
	output term_msg_pkg::msg_flags_t flags
);

	term_msg_pkg::msg_t window;
	term_msg_pkg::msg_t next_window;
	logic [7:0]         is_hex;
	logic [7:0]         is_alnum;
	logic [31:0]        nybbles;
	logic               terminator;

	assign next_window = {window[63:0], rx_byte};
	assign terminator = rx_valid && (rx_byte == 8'h00);

	// decode from the window as it will look after this byte,
	// bit 7 of is_hex / is_alnum is the first character
	for (genvar k = 0; k < 8; k++) begin : g_char
		char_class i_class (
			.ch       (next_window[71 - 8 * k -: 8]),
			.is_hex   (is_hex[7 - k]),
			.is_alnum (is_alnum[7 - k]),
			.nybble   (nybbles[31 - 4 * k -: 4])
		);
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			window <= '0;
			msg_valid <= 1'b0;
			flags <= '0;
		end else begin
			msg_valid <= terminator;
			if (rx_valid) begin
				window <= next_window;
			end
			if (terminator) begin
				flags.is_soundoff <= (next_window[71:8] == "soundoff");
				flags.is_read <= (next_window[71:40] == "rdrd");
				flags.is_write <= (next_window[71:56] == "wr");
				flags.damaged <= ~&is_alnum;
				flags.rd_addr_ok <= &is_hex[3:0];
				flags.wr_check_ok <= &is_hex[5:4];
				flags.hex_val <= nybbles;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/msg_tx.sv ====
// reply holding register and byte-wise transmitter
`default_nettype none

module msg_tx (
	input  logic                 clk,
	input  logic                 arst,
	input  term_msg_pkg::reply_t reply,
	input  logic                 reply_valid,
	output logic                 reply_ready,
	output term_msg_pkg::char_t  tx_byte,
	output logic                 tx_valid,
	input  logic                 tx_ready
);

	term_msg_pkg::reply_t shift_q;
	logic [8:0]           occupied;

	// byte at the top of the shift register goes out first
	assign tx_byte = shift_q[71:64];
	assign tx_valid = occupied[8];
	assign reply_ready = ~|occupied;

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			occupied <= '0;
		end else if (reply_valid && reply_ready) begin
			occupied <= '1;
		end else if (tx_valid && tx_ready) begin
			occupied <= occupied << 1;
		end
	end

	always_ff @(posedge clk) begin
		if (reply_valid && reply_ready) begin
			shift_q <= reply;
		end else if (tx_valid && tx_ready) begin
			shift_q <= shift_q << 8;
		end
	end

endmodule

`default_nettype wire

// ==== design/reg_bank.sv ====
// register file bus target with one-cycle read latency
`default_nettype none

module reg_bank #(
	parameter int NUM_REGS = 16
) (
	input  logic                  clk,
	input  logic                  arst,
	input  term_bus_pkg::mm_req_t bus_req,
	output term_bus_pkg::mm_rsp_t bus_rsp
);

	localparam int IDX_W = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

	term_bus_pkg::data_t regs [NUM_REGS];
	logic [IDX_W-1:0]    idx;
	logic                in_range;

	assign idx = bus_req.addr[IDX_W-1:0];
	// addresses past the top read zero and drop writes
	assign in_range = int'(bus_req.addr) < NUM_REGS;

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
			bus_rsp <= '0;
		end else begin
			bus_rsp.rvalid <= bus_req.read;
			if (bus_req.read) begin
				bus_rsp.rdata <= in_range ? regs[idx] : '0;
			end
			if (bus_req.write && in_range) begin
				regs[idx] <= bus_req.wdata;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/term_bus_pkg.sv ====
// bus address and data types, request and response structs
`default_nettype none

package term_bus_pkg;

	typedef logic [15:0] addr_t;
	typedef logic [31:0] data_t;

	// read and write are single-cycle pulses
	typedef struct packed {
		addr_t addr;
		logic  read;
		logic  write;
		data_t wdata;
	} mm_req_t;

	typedef struct packed {
		data_t rdata;
		logic  rvalid;
	} mm_rsp_t;

endpackage

`default_nettype wire

// ==== design/term_master.sv ====
// command FSM, write integrity check, read capture and reply formatting
`default_nettype none

module term_master (
	input  logic                     clk,
	input  logic                     arst,
	input  logic                     msg_valid,
	input  term_msg_pkg::msg_flags_t flags,
	output term_bus_pkg::mm_req_t    bus_req,
	input  term_bus_pkg::mm_rsp_t    bus_rsp,
	output term_msg_pkg::reply_t     reply,
	output logic                     reply_valid,
	input  logic                     reply_ready
);

	term_msg_pkg::master_state_t state;
	term_msg_pkg::msg_flags_t    msg_q;
	term_bus_pkg::addr_t         addr;
	term_bus_pkg::data_t         wr_data;
	term_bus_pkg::data_t         read_value;
	logic [7:0]                  wr_check;
	logic [63:0]                 read_hex;
	logic [63:0]                 read_hex_w;
	logic [3:0]                  read_progress;
	logic                        start_read;
	logic                        write_ena;
	logic                        write_ok;
	logic                        data_ok;

	////////////////////////////////
	// write integrity check
	////////////////////////////////

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			write_ok <= 1'b0;
		end else begin
			write_ok <= (wr_data[31:24] ^ wr_data[23:16] ^ wr_data[15:8] ^ wr_data[7:0] ^
				addr[15:8] ^ addr[7:0] ^ wr_check) == term_msg_pkg::WR_CHECK_GOOD;
		end
	end

	// data message must be clean hex in the checked positions
	assign data_ok = !flags.damaged && flags.rd_addr_ok && flags.wr_check_ok;

	////////////////////////////////
	// command FSM
	////////////////////////////////

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			state <= term_msg_pkg::ST_IDLE;
			reply_valid <= 1'b0;
			start_read <= 1'b0;
			write_ena <= 1'b0;
		end else begin
			start_read <= 1'b0;
			write_ena <= 1'b0;
			if (reply_valid && reply_ready) begin
				reply_valid <= 1'b0;
			end
			case (state)
				term_msg_pkg::ST_IDLE: begin
					if (msg_valid) state <= term_msg_pkg::ST_MSG_CHECK;
				end
				term_msg_pkg::ST_MSG_CHECK: begin
					if (msg_q.damaged) begin
						state <= term_msg_pkg::ST_IDLE;
					end else if (msg_q.is_soundoff) begin
						state <= term_msg_pkg::ST_SOUNDOFF;
					end else if (msg_q.is_read && msg_q.rd_addr_ok) begin
						state <= term_msg_pkg::ST_READ;
					end else if (msg_q.is_write && msg_q.wr_check_ok && msg_q.rd_addr_ok) begin
						state <= term_msg_pkg::ST_WRITE;
					end else begin
						state <= term_msg_pkg::ST_IDLE;
					end
				end
				term_msg_pkg::ST_SOUNDOFF: begin
					reply_valid <= 1'b1;
					state <= term_msg_pkg::ST_FINISH;
				end
				term_msg_pkg::ST_READ: begin
					start_read <= 1'b1;
					state <= term_msg_pkg::ST_READING;
				end
				term_msg_pkg::ST_READING: begin
					if (read_progress[3]) state <= term_msg_pkg::ST_READ_REPLY;
				end
				term_msg_pkg::ST_READ_REPLY: begin
					reply_valid <= 1'b1;
					state <= term_msg_pkg::ST_FINISH;
				end
				term_msg_pkg::ST_WRITE: begin
					state <= term_msg_pkg::ST_WRITE_DATA;
				end
				term_msg_pkg::ST_WRITE_DATA: begin
					if (msg_valid) begin
						state <= data_ok ? term_msg_pkg::ST_WRITE_VERIFY :
							term_msg_pkg::ST_IDLE;
					end
				end
				term_msg_pkg::ST_WRITE_VERIFY: begin
					// write_ok picks up the new data here
					state <= term_msg_pkg::ST_WRITE_EXEC;
				end
				term_msg_pkg::ST_WRITE_EXEC: begin
					write_ena <= write_ok;
					state <= term_msg_pkg::ST_IDLE;
				end
				term_msg_pkg::ST_FINISH: begin
					if (!reply_valid) state <= term_msg_pkg::ST_IDLE;
				end
				default: state <= term_msg_pkg::ST_IDLE;
			endcase
		end
	end

	// payload captured as the FSM passes through
	always_ff @(posedge clk) begin
		if (state == term_msg_pkg::ST_IDLE && msg_valid) msg_q <= flags;
		if (state == term_msg_pkg::ST_READ || state == term_msg_pkg::ST_WRITE) begin
			addr <= msg_q.hex_val[15:0];
		end
		if (state == term_msg_pkg::ST_WRITE) wr_check <= msg_q.hex_val[23:16];
		if (state == term_msg_pkg::ST_WRITE_DATA && msg_valid) wr_data <= flags.hex_val;
		if (state == term_msg_pkg::ST_SOUNDOFF) reply <= term_msg_pkg::SOUNDOFF_REPLY;
		if (state == term_msg_pkg::ST_READ_REPLY) reply <= {read_hex, 8'h00};
		if (bus_rsp.rvalid) read_value <= bus_rsp.rdata;
		read_hex <= read_hex_w;
	end

	////////////////////////////////
	// read capture
	////////////////////////////////

	hex_to_ascii i_hex (
		.value (read_value),
		.text  (read_hex_w)
	);

	// four cycles from rvalid for capture and conversion
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			read_progress <= '0;
		end else begin
			read_progress <= {read_progress[2:0], bus_rsp.rvalid};
		end
	end

	always_comb begin
		bus_req.addr = addr;
		bus_req.read = start_read;
		bus_req.write = write_ena;
		bus_req.wdata = wr_data;
	end

endmodule

`default_nettype wire

// ==== design/term_msg_pkg.sv ====
// message, character and reply types, controller states, command and reply constants
`default_nettype none

package term_msg_pkg;

	// one ASCII byte on the host streams
	typedef logic [7:0] char_t;

	// nine bytes, first byte received in the top bits
	typedef logic [71:0] msg_t;
	typedef logic [71:0] reply_t;

	// decoded view of one inbound message
	typedef struct packed {
		logic        is_soundoff;
		logic        is_read;
		logic        is_write;
		logic        damaged;
		logic        rd_addr_ok;
		logic        wr_check_ok;
		logic [31:0] hex_val;
	} msg_flags_t;

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_MSG_CHECK,
		ST_SOUNDOFF,
		ST_READ,
		ST_READING,
		ST_READ_REPLY,
		ST_WRITE,
		ST_WRITE_DATA,
		ST_WRITE_VERIFY,
		ST_WRITE_EXEC,
		ST_FINISH
	} master_state_t;

	localparam reply_t SOUNDOFF_REPLY = {"One Two ", 8'h00};

	// xor of data, address and check bytes for an accepted write
	localparam logic [7:0] WR_CHECK_GOOD = 8'hFF;

endpackage

`default_nettype wire

// ==== design/term_top.sv ====
// terminal controller top: receiver, master, transmitter, register bank
`default_nettype none

module term_top #(
	parameter int NUM_REGS = 16
) (
	input  logic                clk,
	input  logic                arst,
	input  term_msg_pkg::char_t rx_byte,
	input  logic                rx_valid,
	output term_msg_pkg::char_t tx_byte,
	output logic                tx_valid,
	input  logic                tx_ready
);

	logic                     msg_valid;
	term_msg_pkg::msg_flags_t flags;
	term_msg_pkg::reply_t     reply;
	logic                     reply_valid;
	logic                     reply_ready;
	term_bus_pkg::mm_req_t    bus_req;
	term_bus_pkg::mm_rsp_t    bus_rsp;

	msg_rx i_rx (
		.clk       (clk),
		.arst      (arst),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid),
		.msg_valid (msg_valid),
		.flags     (flags)
	);

	term_master i_master (
		.clk         (clk),
		.arst        (arst),
		.msg_valid   (msg_valid),
		.flags       (flags),
		.bus_req     (bus_req),
		.bus_rsp     (bus_rsp),
		.reply       (reply),
		.reply_valid (reply_valid),
		.reply_ready (reply_ready)
	);

	msg_tx i_tx (
		.clk         (clk),
		.arst        (arst),
		.reply       (reply),
		.reply_valid (reply_valid),
		.reply_ready (reply_ready),
		.tx_byte     (tx_byte),
		.tx_valid    (tx_valid),
		.tx_ready    (tx_ready)
	);

	reg_bank #(
		.NUM_REGS (NUM_REGS)
	) i_regs (
		.clk     (clk),
		.arst    (arst),
		.bus_req (bus_req),
		.bus_rsp (bus_rsp)
	);

endmodule

`default_nettype wire

// ==== list.f ====
design/term_msg_pkg.sv
design/term_bus_pkg.sv
design/char_class.sv
design/hex_to_ascii.sv
design/msg_rx.sv
design/msg_tx.sv
design/term_master.sv
design/reg_bank.sv
design/term_top.sv
verif/term_checker.sv
verif/term_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module term_tb -f list.f -o term_sim

status=0
./obj_dir/term_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
	exit 0
fi
echo "simulation did not pass, exit code $status"
exit 1

// ==== verif/term_checker.sv ====
// bus and outbound stream protocol assertions, bound into the terminal top level
`default_nettype none

module term_checker (
	input logic                  clk,
	input logic                  arst,
	input term_bus_pkg::mm_req_t bus_req,
	input term_bus_pkg::mm_rsp_t bus_rsp,
	input term_msg_pkg::char_t   tx_byte,
	input logic                  tx_valid,
	input logic                  tx_ready
);

	timeunit 1ns;
	timeprecision 100ps;

	// one bus command per cycle
	a_rd_wr_excl: assert property (@(posedge clk) disable iff (arst)
		!(bus_req.read && bus_req.write))
		else $error("bus read and write high in the same cycle");

	// stalled byte must hold
	a_tx_hold: assert property (@(posedge clk) disable iff (arst)
		(tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_byte)))
		else $error("tx_byte or tx_valid changed while stalled");

	a_rvalid_after_read: assert property (@(posedge clk) disable iff (arst)
		bus_req.read |=> bus_rsp.rvalid)
		else $error("rvalid missing one cycle after read");

	a_rvalid_only_after_read: assert property (@(posedge clk) disable iff (arst)
		bus_rsp.rvalid |-> $past(bus_req.read))
		else $error("rvalid without a read in the previous cycle");

endmodule

bind term_top term_checker i_checker (
	.clk      (clk),
	.arst     (arst),
	.bus_req  (bus_req),
	.bus_rsp  (bus_rsp),
	.tx_byte  (tx_byte),
	.tx_valid (tx_valid),
	.tx_ready (tx_ready)
);

`default_nettype wire

// ==== verif/term_tb.sv ====
// terminal controller testbench: clock, reset, stimulus, reference model, compare, timeout
`default_nettype none

module term_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_REGS = 16;
	localparam int IDX_W = $clog2(NUM_REGS);
	localparam logic [31:0] SEED = 32'h1c69_b6e3;

	logic                clk;
	logic                arst;
	term_msg_pkg::char_t rx_byte;
	logic                rx_valid;
	term_msg_pkg::char_t tx_byte;
	logic                tx_valid;
	logic                tx_ready;

	// reference model state
	logic [31:0] model_regs [NUM_REGS];
	logic        wr_pending;
	logic [15:0] pend_addr;
	logic [7:0]  pend_check;

	term_msg_pkg::reply_t exp_q [$];
	term_msg_pkg::reply_t got_q [$];
	term_msg_pkg::reply_t col_buf;
	term_msg_pkg::reply_t got_reply;
	term_msg_pkg::reply_t exp_reply;
	int                   col_count;
	logic [31:0]          stim_state;
	logic [31:0]          ready_state;
	logic                 random_ready;
	int                   errors;
	int                   test_errors_start;
	int                   tests_run;
	int                   tests_failed;
	int                   replies_checked;
	int                   msgs_sent;
	int                   cycle_count;

	term_top #(
		.NUM_REGS (NUM_REGS)
	) i_dut (
		.clk      (clk),
		.arst     (arst),
		.rx_byte  (rx_byte),
		.rx_valid (rx_valid),
		.tx_byte  (tx_byte),
		.tx_valid (tx_valid),
		.tx_ready (tx_ready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//////////////////////////////
	// helpers and reference model
	//////////////////////////////

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [7:0] hex_char(input logic [3:0] n, input logic lower);
		if (n < 4'd10) return 8'h30 + {4'h0, n};
		if (lower) return 8'h57 + {4'h0, n};
		return 8'h37 + {4'h0, n};
	endfunction

	// eight hex characters, most significant nybble first
	function automatic logic [63:0] to_hex(input logic [31:0] v, input logic lower);
		logic [63:0] s;
		s = '0;
		for (int i = 7; i >= 0; i--) begin
			s = {s[55:0], hex_char(v[4 * i +: 4], lower)};
		end
		return s;
	endfunction

	function automatic logic [3:0] hex_value(input logic [7:0] ch);
		logic [7:0] t;
		t = 8'h00;
		if (ch >= "0" && ch <= "9") t = ch - 8'h30;
		else if (ch >= "a" && ch <= "f") t = ch - 8'h57;
		else if (ch >= "A" && ch <= "F") t = ch - 8'h37;
		return t[3:0];
	endfunction

	function automatic logic [7:0] good_check(input logic [15:0] a, input logic [31:0] d);
		return 8'hFF ^ d[31:24] ^ d[23:16] ^ d[15:8] ^ d[7:0] ^ a[15:8] ^ a[7:0];
	endfunction

	// steps the model by one message; returns 1 with the reply when one is due
	function automatic logic model_reply(input logic [63:0] text,
		output term_msg_pkg::reply_t rep);
		logic [7:0]  ch;
		logic [7:0]  hexm;
		logic        alnum_all;
		logic [31:0] val;
		logic [15:0] a;
		logic [7:0]  x;
		logic        has_reply;
		hexm = '0;
		alnum_all = 1'b1;
		val = '0;
		rep = '0;
		has_reply = 1'b0;
		// bit 7 of hexm is the first character
		for (int i = 0; i < 8; i++) begin
			ch = text[63 - 8 * i -: 8];
			alnum_all = alnum_all && ((ch >= "0" && ch <= "9") ||
				(ch >= "a" && ch <= "z") || (ch >= "A" && ch <= "Z"));
			hexm[7 - i] = (ch >= "0" && ch <= "9") || (ch >= "a" && ch <= "f") ||
				(ch >= "A" && ch <= "F");
			val = {val[27:0], hex_value(ch)};
		end
		if (wr_pending) begin
			wr_pending = 1'b0;
			if (hexm == 8'hFF) begin
				x = val[31:24] ^ val[23:16] ^ val[15:8] ^ val[7:0] ^
					pend_addr[15:8] ^ pend_addr[7:0] ^ pend_check;
				if (x == 8'hFF && int'(pend_addr) < NUM_REGS) begin
					model_regs[pend_addr[IDX_W-1:0]] = val;
				end
			end
		end else if (alnum_all) begin
			if (text == "soundoff") begin
				rep = {"One Two ", 8'h00};
				has_reply = 1'b1;
			end else if (text[63:32] == "rdrd" && hexm[3:0] == 4'hF) begin
				a = val[15:0];
				rep = {to_hex(int'(a) < NUM_REGS ? model_regs[a[IDX_W-1:0]] : 32'h0, 1'b0),
					8'h00};
				has_reply = 1'b1;
			end else if (text[63:48] == "wr" && hexm[5:0] == 6'h3F) begin
				pend_addr = val[15:0];
				pend_check = val[23:16];
				wr_pending = 1'b1;
			end
		end
		return has_reply;
	endfunction

	//////////////////////////////
	// stimulus tasks
	//////////////////////////////

	task automatic send_msg(input logic [63:0] text);
		term_msg_pkg::msg_t m;
		m = {text, 8'h00};
		msgs_sent++;
		for (int i = 0; i < 9; i++) begin
			stim_state = lcg(stim_state);
			repeat (int'(stim_state[31:30]) % 3) begin
				@(posedge clk);
				#1;
				rx_valid = 1'b0;
			end
			@(posedge clk);
			#1;
			rx_byte = m[71 - 8 * i -: 8];
			rx_valid = 1'b1;
		end
		@(posedge clk);
		#1;
		rx_valid = 1'b0;
		rx_byte = 8'h00;
	endtask

	task automatic wait_replies();
		while (exp_q.size() != 0) @(posedge clk);
	endtask

	task automatic issue_msg(input logic [63:0] text);
		term_msg_pkg::reply_t rep;
		if (model_reply(text, rep)) exp_q.push_back(rep);
		send_msg(text);
		wait_replies();
	endtask

	task automatic write_reg(input logic [15:0] a, input logic [31:0] d,
		input logic [7:0] check, input logic lower);
		logic [63:0] t;
		t = to_hex({8'h00, check, a}, lower);
		issue_msg({"wr", t[47:0]});
		issue_msg(to_hex(d, lower));
	endtask

	task automatic read_reg(input logic [15:0] a);
		logic [63:0] t;
		t = to_hex({16'h0000, a}, 1'b0);
		issue_msg({"rdrd", t[31:0]});
	endtask

	task automatic end_test(input string name);
		wait_replies();
		tests_run++;
		if (errors == test_errors_start) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", tests_run, name,
				errors - test_errors_start);
		end
		test_errors_start = errors;
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////

	task automatic check_soundoff();
		issue_msg("soundoff");
		end_test("soundoff reply");
	endtask

	task automatic write_then_read();
		write_reg(16'h0005, 32'hdeadbeef, good_check(16'h0005, 32'hdeadbeef), 1'b1);
		read_reg(16'h0005);
		write_reg(16'h000c, 32'hc0ffee42, good_check(16'h000c, 32'hc0ffee42), 1'b1);
		read_reg(16'h000c);
		end_test("write then read");
	endtask

	task automatic bad_check_drop();
		write_reg(16'h0005, 32'h12345678, good_check(16'h0005, 32'h12345678) ^ 8'h01, 1'b0);
		read_reg(16'h0005);
		end_test("bad check dropped");
	endtask

	task automatic rejected_msgs();
		logic [63:0] t;
		issue_msg("sound.ff");
		issue_msg("hello123");
		issue_msg("rdrd00g1");
		issue_msg("soundoff");
		// data damaged only in the first two characters, check good for the rest
		t = to_hex({8'h00, good_check(16'h0005, 32'h00345678), 16'h0005}, 1'b0);
		issue_msg({"wr", t[47:0]});
		issue_msg("..345678");
		read_reg(16'h0005);
		end_test("damaged and unknown rejected");
	endtask

	task automatic ready_backpressure();
		logic [15:0] a;
		logic [31:0] d;
		random_ready = 1'b1;
		for (int i = 0; i < 4; i++) begin
			stim_state = lcg(stim_state);
			a = {12'h000, stim_state[27:24]};
			stim_state = lcg(stim_state);
			d = stim_state;
			write_reg(a, d, good_check(a, d), d[31]);
			read_reg(a);
			issue_msg("soundoff");
		end
		random_ready = 1'b0;
		end_test("random tx_ready");
	endtask

	task automatic out_of_range();
		// register 0 nonzero, so a read that wraps onto it shows up
		write_reg(16'h0000, 32'h5a5a0f0f, good_check(16'h0000, 32'h5a5a0f0f), 1'b0);
		read_reg(16'h0010);
		write_reg(16'h0013, 32'ha5a5a5a5, good_check(16'h0013, 32'ha5a5a5a5), 1'b1);
		read_reg(16'h0013);
		read_reg(16'h0003);
		end_test("out of range address");
	endtask

	//////////////////////////////
	// output collection and compare
	//////////////////////////////

	always @(posedge clk) begin
		if (!arst && tx_valid && tx_ready) begin
			col_buf = {col_buf[63:0], tx_byte};
			col_count++;
			if (col_count == 9) begin
				got_q.push_back(col_buf);
				col_count = 0;
			end
		end
	end

	always @(negedge clk) begin
		while (got_q.size() > 0) begin
			got_reply = got_q.pop_front();
			if (exp_q.size() == 0) begin
				errors++;
				$display("reply %h arrived when no reply was expected", got_reply);
			end else begin
				exp_reply = exp_q.pop_front();
				replies_checked++;
				for (int i = 0; i < 9; i++) begin
					if (got_reply[71 - 8 * i -: 8] != exp_reply[71 - 8 * i -: 8]) begin
						errors++;
						$display("** Error tx_byte reply %0d byte %0d: expected %h, actual %h",
							replies_checked, i, exp_reply[71 - 8 * i -: 8],
							got_reply[71 - 8 * i -: 8]);
					end
				end
			end
		end
	end

	// host side of the outbound stream
	initial begin
		tx_ready = 1'b1;
		ready_state = SEED;
		forever begin
			@(posedge clk);
			#1;
			ready_state = lcg(ready_state);
			tx_ready = random_ready ? (ready_state[31:30] != 2'b00) : 1'b1;
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count <= 40 * msgs_sent + 200) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout after %0d cycles, %0d messages sent, %0d replies never arrived",
			cycle_count, msgs_sent, exp_q.size());
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		arst = 1'b1;
		rx_byte = 8'h00;
		rx_valid = 1'b0;
		random_ready = 1'b0;
		stim_state = SEED;
		wr_pending = 1'b0;
		pend_addr = '0;
		pend_check = '0;
		col_buf = '0;
		col_count = 0;
		errors = 0;
		test_errors_start = 0;
		tests_run = 0;
		tests_failed = 0;
		replies_checked = 0;
		msgs_sent = 0;
		for (int i = 0; i < NUM_REGS; i++) begin
			model_regs[i] = '0;
		end
		repeat (8) @(posedge clk);
		#1;
		arst = 1'b0;
		repeat (4) @(posedge clk);
		check_soundoff();
		write_then_read();
		bad_check_drop();
		rejected_msgs();
		ready_backpressure();
		out_of_range();
		// drain, so a stray reply is still seen
		repeat (50) @(posedge clk);
		$display("tests %0d, failed %0d, replies checked %0d, errors %0d",
			tests_run, tests_failed, replies_checked, errors);
		if (errors == 0 && tests_failed == 0 && exp_q.size() == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
